/* md_frontend_top.f */
source/core_pkg.sv
source/host_control.sv
source/pad_frame_latch.sv
source/pad_remap.sv
source/pad_port_mux.sv
source/md_frontend_top.sv
bench/md_frontend_sva.sv
bench/md_frontend_tb.sv

/* Makefile */
# Verilator build and run for the Mega Drive front end

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = md_frontend_tb
FILELIST = md_frontend_top.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/md_frontend_tb.sv */
////////////////////
// Front end testbench
// Directed tests of settings, download reset and pads
////////////////////

module md_frontend_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD  = 8;
    localparam int unsigned SEED        = 32'haac0_4b6f;
    // Cycles of reset, settings, download, multitap pads and two player pads
    localparam int          TEST_CYCLES = 10 + 40 + 30 + 45 + 20;
    localparam int          WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 4;

    logic                           clk_74a = 1'b0;
    logic                           reset_i;
    bridge_write_t                  bridge_i;
    logic                           slot_write_req_i;
    logic                           slot_all_done_i;
    logic                           pad_strobe_i;
    pocket_keys_t [NUM_PLAYERS-1:0] cont_keys_i;
    core_settings_t                 settings_o;
    logic                           download_o;
    logic                           core_reset_o;
    pad_set_t                       pads_o;
    logic                           pads_valid_o;

    core_settings_t exp_settings;
    string          test_name;
    int             error_count = 0;

    md_frontend_top uut (.*);

    always #(CLK_PERIOD / 2) clk_74a = ~clk_74a;

    ////////////////////
    // Helpers

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("** Error %s: %s expected %0h, actual %0h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    // One edge, then settle on the falling edge
    task automatic next_cycle();
        @(posedge clk_74a);
        @(negedge clk_74a);
    endtask

    task automatic bridge_write(logic [31:0] addr, logic [31:0] data);
        @(posedge clk_74a);
        bridge_i <= '{wr: 1'b1, addr: addr, data: data};
        @(posedge clk_74a);
        bridge_i.wr <= 1'b0;
        @(negedge clk_74a);
    endtask

    task automatic pulse_slot(logic req, logic done);
        @(posedge clk_74a);
        slot_write_req_i <= req;
        slot_all_done_i  <= done;
        @(posedge clk_74a);
        slot_write_req_i <= 1'b0;
        slot_all_done_i  <= 1'b0;
        @(negedge clk_74a);
    endtask

    task automatic strobe_frame(pocket_keys_t [NUM_PLAYERS-1:0] frame);
        @(posedge clk_74a);
        pad_strobe_i <= 1'b1;
        cont_keys_i  <= frame;
    endtask

    task automatic end_strobes();
        @(posedge clk_74a);
        pad_strobe_i <= 1'b0;
        // Keys between strobes must not reach the pads
        cont_keys_i  <= ~cont_keys_i;
    endtask

    // Register update rule, field from the low data bits
    function automatic core_settings_t apply_write(core_settings_t s, logic [31:0] addr,
                                                   logic [31:0] data);
        case (addr)
            ADDR_FM_CHIP:      s.fm_chip          = data[0];
            ADDR_AUDIO_FILTER: s.audio_filter     = data[1:0];
            ADDR_COMPOSITE:    s.composite_enable = data[0];
            ADDR_SPRITE_LIMIT: s.sprite_limit     = data[0];
            ADDR_MULTITAP:     s.multitap         = data[0];
            ADDR_CPU_TURBO:    s.cpu_turbo        = data[1:0];
            default: ;
        endcase
        return s;
    endfunction

    function automatic genesis_pad_t expected_pad(pocket_keys_t k);
        genesis_pad_t p;
        p = '{z: k[9], y: k[6], x: k[8], mode: k[14], start: k[15], c: k[4], b: k[5],
              a: k[7], up: k[0], down: k[1], left: k[2], right: k[3]};
        return p;
    endfunction

    function automatic pad_set_t expected_set(pocket_keys_t [NUM_PLAYERS-1:0] f, logic tap);
        pad_set_t s;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            if (p < 2 || tap) begin
                s[p] = expected_pad(f[p]);
            end else begin
                s[p] = '0;
            end
        end
        return s;
    endfunction

    task automatic check_frame(pocket_keys_t [NUM_PLAYERS-1:0] frame, logic tap);
        check_value("pads_valid_o", 64'd1, 64'(pads_valid_o));
        check_value("pads_o", 64'(expected_set(frame, tap)), 64'(pads_o));
    endtask

    ////////////////////
    // Tests

    task automatic test_reset();
        test_name = "reset";
        exp_settings = '0;
        exp_settings.sprite_limit = 1'b1;
        repeat (2) @(posedge clk_74a);
        @(negedge clk_74a);
        check_value("core_reset_o", 64'd1, 64'(core_reset_o));
        @(posedge clk_74a);
        reset_i <= 1'b0;
        next_cycle();
        check_value("settings_o", 64'(exp_settings), 64'(settings_o));
        check_value("download_o", 64'd0, 64'(download_o));
        check_value("core_reset_o", 64'd0, 64'(core_reset_o));
        check_value("pads_valid_o", 64'd0, 64'(pads_valid_o));
        check_value("pads_o", 64'd0, 64'(pads_o));
    endtask

    task automatic test_settings();
        logic [31:0] addrs [6] = '{ADDR_FM_CHIP, ADDR_AUDIO_FILTER, ADDR_COMPOSITE,
                                   ADDR_SPRITE_LIMIT, ADDR_MULTITAP, ADDR_CPU_TURBO};
        logic [31:0] others [5] = '{32'h0000_0010, 32'h0000_0031, 32'h00A0_0001,
                                    32'h0F00_0000, 32'h2000_0000};
        logic [31:0] data;
        test_name = "settings";
        repeat (2) begin
            foreach (addrs[i]) begin
                data = $urandom;
                bridge_write(addrs[i], data);
                exp_settings = apply_write(exp_settings, addrs[i], data);
                check_value("settings_o", 64'(exp_settings), 64'(settings_o));
            end
        end
        // Near misses, the last one also outside the ROM window
        others[4] = {4'h2, 28'($urandom)};
        foreach (others[i]) begin
            bridge_write(others[i], $urandom);
            check_value("settings_o", 64'(exp_settings), 64'(settings_o));
        end
    endtask

    task automatic test_download();
        test_name = "download";
        bridge_write(32'h0000_0100, $urandom);
        pulse_slot(1'b1, 1'b0);
        check_value("download_o", 64'd1, 64'(download_o));
        check_value("core_reset_o", 64'd0, 64'(core_reset_o));
        bridge_write({ROM_WINDOW, 28'($urandom)}, $urandom);
        next_cycle();
        check_value("core_reset_o", 64'd1, 64'(core_reset_o));
        // Leaving the window drops the reset one cycle late
        bridge_write(32'h0000_0100, $urandom);
        check_value("core_reset_o", 64'd1, 64'(core_reset_o));
        next_cycle();
        check_value("core_reset_o", 64'd0, 64'(core_reset_o));
        bridge_write({ROM_WINDOW, 28'($urandom)}, $urandom);
        next_cycle();
        check_value("core_reset_o", 64'd1, 64'(core_reset_o));
        pulse_slot(1'b0, 1'b1);
        check_value("download_o", 64'd0, 64'(download_o));
        next_cycle();
        check_value("core_reset_o", 64'd0, 64'(core_reset_o));
        // Request wins over a simultaneous completion
        pulse_slot(1'b1, 1'b1);
        check_value("download_o", 64'd1, 64'(download_o));
        pulse_slot(1'b0, 1'b1);
        check_value("download_o", 64'd0, 64'(download_o));
    endtask

    task automatic test_pads_multitap();
        pocket_keys_t [NUM_PLAYERS-1:0] frame;
        test_name = "pads_multitap";
        bridge_write(ADDR_MULTITAP, 32'h0000_0001);
        exp_settings.multitap = 1'b1;
        check_value("settings_o", 64'(exp_settings), 64'(settings_o));
        repeat (6) begin
            frame = {$urandom, $urandom};
            strobe_frame(frame);
            end_strobes();
            repeat (2) @(posedge clk_74a);
            @(negedge clk_74a);
            check_frame(frame, 1'b1);
            next_cycle();
            check_value("pads_valid_o", 64'd0, 64'(pads_valid_o));
        end
    endtask

    task automatic test_pads_two_players();
        pocket_keys_t [NUM_PLAYERS-1:0] frames [3];
        test_name = "pads_two_players";
        bridge_write(ADDR_MULTITAP, 32'h0000_0000);
        exp_settings.multitap = 1'b0;
        check_value("settings_o", 64'(exp_settings), 64'(settings_o));
        // All keys held so the gated ports have something to hide
        frames[0] = '1;
        frames[1] = {$urandom, $urandom};
        frames[2] = {$urandom, $urandom};
        foreach (frames[i]) begin
            strobe_frame(frames[i]);
        end
        end_strobes();
        @(negedge clk_74a);
        check_frame(frames[0], 1'b0);
        for (int i = 1; i < 3; i++) begin
            next_cycle();
            check_frame(frames[i], 1'b0);
        end
        next_cycle();
        check_value("pads_valid_o", 64'd0, 64'(pads_valid_o));
    endtask

    ////////////////////
    // Run

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        void'($urandom(SEED));
        reset_i          <= 1'b1;
        bridge_i         <= '0;
        slot_write_req_i <= 1'b0;
        slot_all_done_i  <= 1'b0;
        pad_strobe_i     <= 1'b0;
        cont_keys_i      <= '0;
        test_reset();
        test_settings();
        test_download();
        test_pads_multitap();
        test_pads_two_players();
        if (error_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

/* bench/md_frontend_sva.sv */
////////////////////
// Front end timing assertions
// Bound to the top level
////////////////////

module md_frontend_sva import core_pkg::*; (
    input logic clk_74a,
    input logic reset_i,
    input logic slot_write_req_i,
    input logic pad_strobe_i,
    input logic download_o,
    input logic core_reset_o,
    input logic pads_valid_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // Latch, lane and mux each add one cycle
    pad_latency: assert property (
        @(posedge clk_74a) disable iff (reset_i)
        pads_valid_o == $past(pad_strobe_i, 3)
    ) else $error("pads_valid_o did not follow pad_strobe_i by three cycles");

    core_reset_follows: assert property (
        @(posedge clk_74a) reset_i |=> core_reset_o
    ) else $error("core_reset_o was low in the cycle after reset_i");

    download_rise: assert property (
        @(posedge clk_74a) disable iff (reset_i)
        slot_write_req_i |=> download_o
    ) else $error("download_o did not rise after a write request");

endmodule

bind md_frontend_top md_frontend_sva u_timing_checks (
    .clk_74a          (clk_74a),
    .reset_i          (reset_i),
    .slot_write_req_i (slot_write_req_i),
    .pad_strobe_i     (pad_strobe_i),
    .download_o       (download_o),
    .core_reset_o     (core_reset_o),
    .pads_valid_o     (pads_valid_o)
);

/* source/md_frontend_top.sv */
////////////////////
// Mega Drive host front end
// Host settings, download reset and controller mapping
////////////////////

module md_frontend_top import core_pkg::*; (
    input  logic                           clk_74a,
    input  logic                           reset_i,
    input  bridge_write_t                  bridge_i,
    input  logic                           slot_write_req_i,
    input  logic                           slot_all_done_i,
    input  logic                           pad_strobe_i,
    input  pocket_keys_t [NUM_PLAYERS-1:0] cont_keys_i,
    output core_settings_t                 settings_o,
    output logic                           download_o,
    output logic                           core_reset_o,
    output pad_set_t                       pads_o,
    output logic                           pads_valid_o
);

    core_settings_t                 settings;
    pocket_keys_t [NUM_PLAYERS-1:0] latched_keys;
    logic                           latched_valid;
    pad_set_t                       lane_pads;
    logic [NUM_PLAYERS-1:0]         lane_valid;

    ////////////////////
    // Host side

    host_control u_host_control (
        .clk_74a          (clk_74a),
        .reset_i          (reset_i),
        .bridge_i         (bridge_i),
        .slot_write_req_i (slot_write_req_i),
        .slot_all_done_i  (slot_all_done_i),
        .settings_o       (settings),
        .download_o       (download_o),
        .core_reset_o     (core_reset_o)
    );

    assign settings_o = settings;

    ////////////////////
    // Controller path

    pad_frame_latch u_pad_frame_latch (
        .clk_74a      (clk_74a),
        .reset_i      (reset_i),
        .pad_strobe_i (pad_strobe_i),
        .cont_keys_i  (cont_keys_i),
        .keys_o       (latched_keys),
        .keys_valid_o (latched_valid)
    );

    // One lane per controller port
    for (genvar g = 0; g < NUM_PLAYERS; g++) begin : g_lane
        pad_remap u_pad_remap (
            .clk_74a      (clk_74a),
            .reset_i      (reset_i),
            .keys_i       (latched_keys[g]),
            .keys_valid_i (latched_valid),
            .pad_o        (lane_pads[g]),
            .pad_valid_o  (lane_valid[g])
        );
    end

    pad_port_mux u_pad_port_mux (
        .clk_74a      (clk_74a),
        .reset_i      (reset_i),
        .pads_i       (lane_pads),
        .pads_valid_i (lane_valid),
        .multitap_i   (settings.multitap),
        .pads_o       (pads_o),
        .pads_valid_o (pads_valid_o)
    );

endmodule

/* source/pad_port_mux.sv */
////////////////////
// Pad port mux
// Collects the lane outputs, gates players 3 and 4 by
// multitap and presents the pad set with a strobe
////////////////////

module pad_port_mux import core_pkg::*; (
    input  logic                   clk_74a,
    input  logic                   reset_i,
    input  pad_set_t               pads_i,
    input  logic [NUM_PLAYERS-1:0] pads_valid_i,
    input  logic                   multitap_i,
    output pad_set_t               pads_o,
    output logic                   pads_valid_o
);

    localparam genesis_pad_t PAD_RELEASED = genesis_pad_t'({PAD_BUTTONS{1'b0}});

    pad_set_t pads_gated;
    pad_set_t pads_q;
    logic     valid_q;
    logic     all_valid;

    assign all_valid = &pads_valid_i;

    // Ports 1 and 2 are always wired, the rest sit behind the multitap
    always_comb begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            if (p >= 2 && !multitap_i) begin
                pads_gated[p] = PAD_RELEASED;
            end else begin
                pads_gated[p] = pads_i[p];
            end
        end
    end

    always_ff @(posedge clk_74a) begin
        if (reset_i) begin
            pads_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= all_valid;
            if (all_valid) begin
                pads_q <= pads_gated;
            end
        end
    end

    assign pads_o       = pads_q;
    assign pads_valid_o = valid_q;

endmodule

/* source/pad_remap.sv */
////////////////////
// Pad remap lane
// Permutes one Pocket key word into a Genesis pad
////////////////////

module pad_remap import core_pkg::*; (
    input  logic         clk_74a,
    input  logic         reset_i,
    input  pocket_keys_t keys_i,
    input  logic         keys_valid_i,
    output genesis_pad_t pad_o,
    output logic         pad_valid_o
);

    genesis_pad_t pad_q;
    logic         valid_q;

    // Pocket key bit to pad button, other key bits unused
    always_ff @(posedge clk_74a) begin
        if (keys_valid_i) begin
            pad_q.up    <= keys_i[0];
            pad_q.down  <= keys_i[1];
            pad_q.left  <= keys_i[2];
            pad_q.right <= keys_i[3];
            pad_q.a     <= keys_i[7];
            pad_q.b     <= keys_i[5];
            pad_q.c     <= keys_i[4];
            pad_q.start <= keys_i[15];
            pad_q.mode  <= keys_i[14];
            pad_q.x     <= keys_i[8];
            pad_q.y     <= keys_i[6];
            pad_q.z     <= keys_i[9];
        end
    end

    always_ff @(posedge clk_74a) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= keys_valid_i;
        end
    end

    assign pad_o       = pad_q;
    assign pad_valid_o = valid_q;

endmodule

/* source/pad_frame_latch.sv */
////////////////////
// Pad frame latch
// Captures all controller key words on the host strobe
////////////////////

module pad_frame_latch import core_pkg::*; (
    input  logic                           clk_74a,
    input  logic                           reset_i,
    input  logic                           pad_strobe_i,
    input  pocket_keys_t [NUM_PLAYERS-1:0] cont_keys_i,
    output pocket_keys_t [NUM_PLAYERS-1:0] keys_o,
    output logic                           keys_valid_o
);

    pocket_keys_t [NUM_PLAYERS-1:0] keys_q;
    logic                           valid_q;

    // Whole frame is taken at once so the lanes stay consistent
    always_ff @(posedge clk_74a) begin
        if (pad_strobe_i) begin
            keys_q <= cont_keys_i;
        end
    end

    always_ff @(posedge clk_74a) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pad_strobe_i;
        end
    end

    assign keys_o       = keys_q;
    assign keys_valid_o = valid_q;

endmodule

/* source/host_control.sv */
////////////////////
// Host control
// Decodes bridge writes into the core settings, tracks
// the ROM download and holds the console core in reset
// while cartridge data is arriving
////////////////////

module host_control import core_pkg::*; (
    input  logic           clk_74a,
    input  logic           reset_i,
    input  bridge_write_t  bridge_i,
    input  logic           slot_write_req_i,
    input  logic           slot_all_done_i,
    output core_settings_t settings_o,
    output logic           download_o,
    output logic           core_reset_o
);

    core_settings_t settings_q;
    logic           download_q;
    logic           rom_window_q;
    logic           core_reset_q;

    ////////////////////
    // Settings registers

    always_ff @(posedge clk_74a) begin
        if (reset_i) begin
            settings_q <= SETTINGS_DEFAULT;
        end else if (bridge_i.wr) begin
            // Field comes from the low bits of the write data
            case (bridge_i.addr)
                ADDR_FM_CHIP:      settings_q.fm_chip          <= bridge_i.data[0];
                ADDR_AUDIO_FILTER: settings_q.audio_filter     <= bridge_i.data[1:0];
                ADDR_COMPOSITE:    settings_q.composite_enable <= bridge_i.data[0];
                ADDR_SPRITE_LIMIT: settings_q.sprite_limit     <= bridge_i.data[0];
                ADDR_MULTITAP:     settings_q.multitap         <= bridge_i.data[0];
                ADDR_CPU_TURBO:    settings_q.cpu_turbo        <= bridge_i.data[1:0];
                default: begin
                end
            endcase
        end
    end

    ////////////////////
    // Download tracking

    // Request has priority over completion
    always_ff @(posedge clk_74a) begin
        if (reset_i) begin
            download_q <= 1'b0;
        end else if (slot_write_req_i) begin
            download_q <= 1'b1;
        end else if (slot_all_done_i) begin
            download_q <= 1'b0;
        end
    end

    // Remember where the last bridge write went
    always_ff @(posedge clk_74a) begin
        if (reset_i) begin
            rom_window_q <= 1'b0;
        end else if (bridge_i.wr) begin
            rom_window_q <= (bridge_i.addr[31:28] == ROM_WINDOW);
        end
    end

    ////////////////////
    // Console core reset

    always_ff @(posedge clk_74a) begin
        if (reset_i) begin
            core_reset_q <= 1'b1;
        end else begin
            core_reset_q <= download_q & rom_window_q;
        end
    end

    assign settings_o   = settings_q;
    assign download_o   = download_q;
    assign core_reset_o = core_reset_q;

endmodule

/* source/core_pkg.sv */
////////////////////
// Mega Drive front end definitions
// Settings addresses, ROM window, pad counts and shared
// structs used by the host control and controller paths
////////////////////

package core_pkg;

    ////////////////////
    // Sizes

    localparam int NUM_PLAYERS = 4;
    localparam int PAD_BUTTONS = 12;

    ////////////////////
    // Settings register addresses

    localparam logic [31:0] ADDR_FM_CHIP      = 32'h00A0_0000;
    localparam logic [31:0] ADDR_AUDIO_FILTER = 32'h00F0_0000;
    localparam logic [31:0] ADDR_COMPOSITE    = 32'h0000_0020;
    localparam logic [31:0] ADDR_SPRITE_LIMIT = 32'h0000_0030;
    localparam logic [31:0] ADDR_MULTITAP     = 32'h0000_0000;
    localparam logic [31:0] ADDR_CPU_TURBO    = 32'h00C0_0000;

    // Top address nibble of cartridge data
    localparam logic [3:0] ROM_WINDOW = 4'h1;

    ////////////////////
    // Shared types

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
    } bridge_write_t;

    typedef struct packed {
        logic       fm_chip;          // 0 = YM2612, 1 = YM3438
        logic [1:0] audio_filter;
        logic       composite_enable;
        logic       sprite_limit;
        logic       multitap;
        logic [1:0] cpu_turbo;
    } core_settings_t;

    // Power-up state, sprite limit on
    localparam core_settings_t SETTINGS_DEFAULT = '{
        fm_chip:          1'b0,
        audio_filter:     2'b00,
        composite_enable: 1'b0,
        sprite_limit:     1'b1,
        multitap:         1'b0,
        cpu_turbo:        2'b00
    };

    typedef logic [15:0] pocket_keys_t;

    // Active high buttons, z in the top bit
    typedef struct packed {
        logic z;
        logic y;
        logic x;
        logic mode;
        logic start;
        logic c;
        logic b;
        logic a;
        logic up;
        logic down;
        logic left;
        logic right;
    } genesis_pad_t;

    typedef genesis_pad_t [NUM_PLAYERS-1:0] pad_set_t;

endpackage
